//--- Makefile
BIN  := obj_dir/Vtb_rv_decode
SRCS := $(wildcard rtl/*.sv test/*.sv)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF '** PASS **'

$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f files.f --top-module tb_rv_decode -Mdir obj_dir

clean:
	rm -rf obj_dir

//--- files.f
rtl/rv_decode_pkg.sv
rtl/if_de_reg.sv
rtl/alu_op_decode.sv
rtl/system_decode.sv
rtl/opcode_decode.sv
rtl/rv_decode.sv
test/tb_clock_gen.sv
test/rv_decode_assertions.sv
test/tb_rv_decode.sv

//--- rtl/alu_op_decode.sv
// ------------------------------------------------------------
// ALU operation lookup from funct3 and funct7
// Gives the arithmetic op, the branch compare and a non-base flag
// ------------------------------------------------------------
`timescale 1ns/1ps

module alu_op_decode (
  input  logic [2:0]             funct3_i,
  input  logic [6:0]             funct7_i,
  input  logic                   is_op_i,
  output rv_decode_pkg::alu_op_e arith_op_o,
  output rv_decode_pkg::alu_op_e branch_op_o,
  output logic                   branch_valid_o,
  output logic                   op_nonbase_o
);

  // ADDI has no sub form, the immediate sits in funct7
  always_comb begin
    case (funct3_i)
      rv_decode_pkg::f3_add_sub: begin
        arith_op_o = (is_op_i && funct7_i[5]) ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
      end
      rv_decode_pkg::f3_sll:  arith_op_o = rv_decode_pkg::alu_sll;
      rv_decode_pkg::f3_slt:  arith_op_o = rv_decode_pkg::alu_slt;
      rv_decode_pkg::f3_sltu: arith_op_o = rv_decode_pkg::alu_sltu;
      rv_decode_pkg::f3_xor:  arith_op_o = rv_decode_pkg::alu_xor;
      rv_decode_pkg::f3_srl_sra: begin
        arith_op_o = funct7_i[5] ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
      end
      rv_decode_pkg::f3_or:   arith_op_o = rv_decode_pkg::alu_or;
      default:                arith_op_o = rv_decode_pkg::alu_and;
    endcase
  end

  always_comb begin
    branch_valid_o = 1'b1;
    case (funct3_i)
      rv_decode_pkg::f3_beq:  branch_op_o = rv_decode_pkg::alu_seq;
      rv_decode_pkg::f3_bne:  branch_op_o = rv_decode_pkg::alu_sne;
      rv_decode_pkg::f3_blt:  branch_op_o = rv_decode_pkg::alu_slt;
      rv_decode_pkg::f3_bge:  branch_op_o = rv_decode_pkg::alu_sge;
      rv_decode_pkg::f3_bltu: branch_op_o = rv_decode_pkg::alu_sltu;
      rv_decode_pkg::f3_bgeu: branch_op_o = rv_decode_pkg::alu_sgeu;
      default: begin
        branch_op_o    = rv_decode_pkg::alu_add;
        branch_valid_o = 1'b0;
      end
    endcase
  end

  // Anything beyond the two base funct7 codes goes to the coprocessor
  assign op_nonbase_o = (funct7_i != rv_decode_pkg::f7_base) &&
                        (funct7_i != rv_decode_pkg::f7_alt);

endmodule

//--- rtl/if_de_reg.sv
// ------------------------------------------------------------
// Pipeline register between fetch and decode
// Kill beats stall, ebreak replaces the fetch word on injection
// ------------------------------------------------------------
`timescale 1ns/1ps

module if_de_reg #(
  parameter logic [rv_decode_pkg::xlen-1:0] start_pc = 32'h0000_0200
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  logic                           kill_i,
  input  logic                           inject_ebreak_i,
  input  logic [rv_decode_pkg::xlen-1:0] inst_i,
  input  logic [rv_decode_pkg::xlen-1:0] pc_i,
  input  logic                           compressed_i,
  output rv_decode_pkg::de_inst_t        de_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      de_o.pc         <= start_pc;
      de_o.inst       <= rv_decode_pkg::rv_nop;
      de_o.compressed <= 1'b0;
    end else if (kill_i) begin
      // Squash to a NOP, PC stays for the trap logic
      de_o.inst <= rv_decode_pkg::rv_nop;
    end else if (!stall_i) begin
      de_o.pc         <= pc_i;
      de_o.compressed <= compressed_i;
      de_o.inst       <= inject_ebreak_i ? rv_decode_pkg::ebreak_inst : inst_i;
    end
  end

endmodule

//--- rtl/opcode_decode.sv
// ------------------------------------------------------------
// Main opcode table of the decode stage
// Builds the control struct from the registered instruction
// ------------------------------------------------------------
`timescale 1ns/1ps

module opcode_decode (
  input  rv_decode_pkg::de_inst_t de_i,
  input  rv_decode_pkg::prv_e     prv_i,
  input  logic                    kill_i,
  output rv_decode_pkg::de_ctrl_t ctrl_o
);

  rv_decode_pkg::opcode_e   opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic                     rs1_rd_zero;
  rv_decode_pkg::alu_op_e   arith_op;
  rv_decode_pkg::alu_op_e   branch_op;
  logic                     branch_valid;
  logic                     op_nonbase;
  rv_decode_pkg::sys_ctrl_t sys;

  assign opcode      = rv_decode_pkg::opcode_e'(de_i.inst[6:0]);
  assign funct3      = de_i.inst[14:12];
  assign funct7      = de_i.inst[31:25];
  assign rs1_rd_zero = (de_i.inst[19:15] == 5'd0) && (de_i.inst[11:7] == 5'd0);

  alu_op_decode u_alu_op_decode (
    .funct3_i       (funct3),
    .funct7_i       (funct7),
    .is_op_i        (opcode == rv_decode_pkg::opc_op),
    .arith_op_o     (arith_op),
    .branch_op_o    (branch_op),
    .branch_valid_o (branch_valid),
    .op_nonbase_o   (op_nonbase)
  );

  system_decode u_system_decode (
    .inst_i (de_i.inst),
    .prv_i  (prv_i),
    .sys_o  (sys)
  );

  always_comb begin
    ctrl_o            = '0;
    ctrl_o.alu_op     = rv_decode_pkg::alu_add;
    ctrl_o.src_a_sel  = rv_decode_pkg::src_a_rs1;
    ctrl_o.src_b_sel  = rv_decode_pkg::src_b_imm;
    ctrl_o.src_c_sel  = rv_decode_pkg::src_c_zero;
    ctrl_o.imm_type   = rv_decode_pkg::imm_i;
    ctrl_o.wb_src_sel = rv_decode_pkg::wb_alu;
    ctrl_o.uses_rs1   = 1'b1;
    ctrl_o.rs1_addr   = de_i.inst[19:15];
    ctrl_o.rs2_addr   = de_i.inst[24:20];
    // rs3 shares the rd field
    ctrl_o.rs3_addr   = de_i.inst[11:7];
    ctrl_o.dmem_size  = {1'b0, funct3[1:0]};
    ctrl_o.dmem_type  = funct3;
    case (opcode)
      rv_decode_pkg::opc_load: begin
        ctrl_o.wr_reg     = 1'b1;
        ctrl_o.dmem_en    = 1'b1;
        ctrl_o.wb_src_sel = rv_decode_pkg::wb_mem;
      end
      rv_decode_pkg::opc_store: begin
        ctrl_o.dmem_en  = 1'b1;
        ctrl_o.dmem_wen = 1'b1;
        ctrl_o.uses_rs2 = 1'b1;
        ctrl_o.imm_type = rv_decode_pkg::imm_s;
      end
      rv_decode_pkg::opc_branch: begin
        ctrl_o.src_b_sel = rv_decode_pkg::src_b_rs2;
        ctrl_o.uses_rs2  = 1'b1;
        ctrl_o.alu_op    = branch_op;
        ctrl_o.illegal   = !branch_valid;
      end
      // Link value is PC plus four, the target adder sits elsewhere
      rv_decode_pkg::opc_jal: begin
        ctrl_o.uses_rs1  = 1'b0;
        ctrl_o.src_a_sel = rv_decode_pkg::src_a_pc;
        ctrl_o.src_b_sel = rv_decode_pkg::src_b_four;
        ctrl_o.wr_reg    = 1'b1;
        ctrl_o.jal       = 1'b1;
      end
      rv_decode_pkg::opc_jalr: begin
        ctrl_o.src_a_sel = rv_decode_pkg::src_a_pc;
        ctrl_o.src_b_sel = rv_decode_pkg::src_b_four;
        ctrl_o.wr_reg    = 1'b1;
        ctrl_o.jalr      = 1'b1;
        ctrl_o.illegal   = (funct3 != 3'b000);
      end
      rv_decode_pkg::opc_misc_mem: begin
        if (funct3 == rv_decode_pkg::f3_fence && de_i.inst[31:28] == 4'd0 && rs1_rd_zero) begin
          // Memory is in order already, nothing to do
          ctrl_o.illegal = 1'b0;
        end else if (funct3 == rv_decode_pkg::f3_fence_i &&
                     de_i.inst[31:20] == 12'd0 && rs1_rd_zero) begin
          ctrl_o.fence_i = 1'b1;
        end else begin
          ctrl_o.illegal = 1'b1;
        end
      end
      rv_decode_pkg::opc_op_imm: begin
        ctrl_o.alu_op = arith_op;
        ctrl_o.wr_reg = 1'b1;
      end
      rv_decode_pkg::opc_op: begin
        ctrl_o.src_b_sel = rv_decode_pkg::src_b_rs2;
        ctrl_o.alu_op    = arith_op;
        ctrl_o.wr_reg    = 1'b1;
        ctrl_o.uses_rs2  = 1'b1;
        if (op_nonbase && !kill_i) begin
          ctrl_o.pcpi_valid = 1'b1;
          ctrl_o.uses_pcpi  = 1'b1;
          ctrl_o.wb_src_sel = rv_decode_pkg::wb_pcpi;
        end
      end
      rv_decode_pkg::opc_custom: begin
        ctrl_o.src_b_sel = rv_decode_pkg::src_b_rs2;
        ctrl_o.src_c_sel = rv_decode_pkg::src_c_rs3;
        ctrl_o.wr_reg    = 1'b1;
        ctrl_o.uses_rs2  = 1'b1;
        ctrl_o.uses_rs3  = 1'b1;
        if (!kill_i) begin
          ctrl_o.pcpi_valid = 1'b1;
          ctrl_o.uses_pcpi  = 1'b1;
          ctrl_o.wb_src_sel = rv_decode_pkg::wb_pcpi;
        end
      end
      rv_decode_pkg::opc_system: begin
        ctrl_o.wb_src_sel = rv_decode_pkg::wb_csr;
        ctrl_o.wr_reg     = sys.wr_reg;
        ctrl_o.illegal    = sys.illegal;
        ctrl_o.sys        = sys;
      end
      rv_decode_pkg::opc_auipc: begin
        ctrl_o.uses_rs1  = 1'b0;
        ctrl_o.src_a_sel = rv_decode_pkg::src_a_pc;
        ctrl_o.imm_type  = rv_decode_pkg::imm_u;
        ctrl_o.wr_reg    = 1'b1;
      end
      rv_decode_pkg::opc_lui: begin
        ctrl_o.uses_rs1  = 1'b0;
        ctrl_o.src_a_sel = rv_decode_pkg::src_a_zero;
        ctrl_o.imm_type  = rv_decode_pkg::imm_u;
        ctrl_o.wr_reg    = 1'b1;
      end
      default: ctrl_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- rtl/rv_decode.sv
// ------------------------------------------------------------
// Decode stage top level of the RV32 core
// IF/DE register followed by the combinational decoder
// ------------------------------------------------------------
`timescale 1ns/1ps

module rv_decode #(
  parameter logic [rv_decode_pkg::xlen-1:0] start_pc = 32'h0000_0200
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [rv_decode_pkg::xlen-1:0] inst_i,
  input  logic [rv_decode_pkg::xlen-1:0] pc_i,
  input  logic                           compressed_i,
  input  logic                           stall_i,
  input  logic                           kill_i,
  input  logic                           inject_ebreak_i,
  input  rv_decode_pkg::prv_e            prv_i,
  output rv_decode_pkg::de_inst_t        de_o,
  output rv_decode_pkg::de_ctrl_t        ctrl_o
);

  if_de_reg #(
    .start_pc (start_pc)
  ) u_if_de_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_i),
    .kill_i          (kill_i),
    .inject_ebreak_i (inject_ebreak_i),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .compressed_i    (compressed_i),
    .de_o            (de_o)
  );

  // Same-cycle decode of the registered word
  opcode_decode u_opcode_decode (
    .de_i   (de_o),
    .prv_i  (prv_i),
    .kill_i (kill_i),
    .ctrl_o (ctrl_o)
  );

endmodule

//--- rtl/rv_decode_pkg.sv
// ------------------------------------------------------------
// Shared types and encodings of the RV32 decode stage
// Opcodes, funct fields, select codes and the control structs
// ------------------------------------------------------------
package rv_decode_pkg;

  parameter int unsigned xlen = 32;

  // ADDI x0, x0, 0
  parameter logic [xlen-1:0] rv_nop      = 32'h0000_0013;
  parameter logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_custom   = 7'b0001011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  // OP and OP_IMM
  parameter logic [2:0] f3_add_sub = 3'b000;
  parameter logic [2:0] f3_sll     = 3'b001;
  parameter logic [2:0] f3_slt     = 3'b010;
  parameter logic [2:0] f3_sltu    = 3'b011;
  parameter logic [2:0] f3_xor     = 3'b100;
  parameter logic [2:0] f3_srl_sra = 3'b101;
  parameter logic [2:0] f3_or      = 3'b110;
  parameter logic [2:0] f3_and     = 3'b111;

  // BRANCH
  parameter logic [2:0] f3_beq  = 3'b000;
  parameter logic [2:0] f3_bne  = 3'b001;
  parameter logic [2:0] f3_blt  = 3'b100;
  parameter logic [2:0] f3_bge  = 3'b101;
  parameter logic [2:0] f3_bltu = 3'b110;
  parameter logic [2:0] f3_bgeu = 3'b111;

  parameter logic [2:0] f3_fence   = 3'b000;
  parameter logic [2:0] f3_fence_i = 3'b001;

  // SYSTEM
  parameter logic [2:0] f3_priv   = 3'b000;
  parameter logic [2:0] f3_csrrw  = 3'b001;
  parameter logic [2:0] f3_csrrs  = 3'b010;
  parameter logic [2:0] f3_csrrc  = 3'b011;
  parameter logic [2:0] f3_csrrwi = 3'b101;
  parameter logic [2:0] f3_csrrsi = 3'b110;
  parameter logic [2:0] f3_csrrci = 3'b111;

  parameter logic [11:0] f12_ecall  = 12'h000;
  parameter logic [11:0] f12_ebreak = 12'h001;
  parameter logic [11:0] f12_wfi    = 12'h105;
  parameter logic [11:0] f12_mret   = 12'h302;
  parameter logic [11:0] f12_dret   = 12'h7b2;

  parameter logic [6:0] f7_base = 7'h00;
  parameter logic [6:0] f7_alt  = 7'h20;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl,
    alu_sra, alu_or, alu_and, alu_seq, alu_sne, alu_sge, alu_sgeu
  } alu_op_e;

  typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_sel_e;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_sel_e;
  typedef enum logic {src_c_zero, src_c_rs3} src_c_sel_e;
  typedef enum logic [1:0] {imm_i, imm_s, imm_u} imm_type_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_csr, wb_pcpi} wb_src_sel_e;
  typedef enum logic [2:0] {csr_idle, csr_read, csr_write, csr_set, csr_clear} csr_cmd_e;
  typedef enum logic [1:0] {prv_user = 2'b00, prv_machine = 2'b11} prv_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            compressed;
  } de_inst_t;

  typedef struct packed {
    logic     ecall;
    logic     ebreak;
    logic     eret;
    logic     dret;
    logic     wfi;
    csr_cmd_e csr_cmd;
    logic     csr_imm_sel;
    logic     wr_reg;
    logic     illegal;
  } sys_ctrl_t;

  typedef struct packed {
    alu_op_e     alu_op;
    src_a_sel_e  src_a_sel;
    src_b_sel_e  src_b_sel;
    src_c_sel_e  src_c_sel;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rs3_addr;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        uses_rs3;
    imm_type_e   imm_type;
    wb_src_sel_e wb_src_sel;
    logic        dmem_en;
    logic        dmem_wen;
    logic [2:0]  dmem_size;
    logic [2:0]  dmem_type;
    logic        wr_reg;
    logic        illegal;
    logic        jal;
    logic        jalr;
    logic        fence_i;
    logic        pcpi_valid;
    logic        uses_pcpi;
    sys_ctrl_t   sys;
  } de_ctrl_t;

endpackage

//--- rtl/system_decode.sv
// ------------------------------------------------------------
// SYSTEM opcode decode into trap events and CSR commands
// Only valid while the opcode decoder sees a SYSTEM opcode
// ------------------------------------------------------------
`timescale 1ns/1ps

module system_decode (
  input  logic [rv_decode_pkg::xlen-1:0] inst_i,
  input  rv_decode_pkg::prv_e            prv_i,
  output rv_decode_pkg::sys_ctrl_t       sys_o
);

  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        rs1_zero;
  logic        rd_zero;

  assign funct3   = inst_i[14:12];
  assign funct12  = inst_i[31:20];
  assign rs1_zero = (inst_i[19:15] == 5'd0);
  assign rd_zero  = (inst_i[11:7] == 5'd0);

  always_comb begin
    sys_o             = '0;
    sys_o.csr_cmd     = rv_decode_pkg::csr_idle;
    sys_o.csr_imm_sel = funct3[2];
    sys_o.wr_reg      = (funct3 != rv_decode_pkg::f3_priv);
    case (funct3)
      rv_decode_pkg::f3_priv: begin
        if (rs1_zero && rd_zero) begin
          case (funct12)
            rv_decode_pkg::f12_ecall:  sys_o.ecall = 1'b1;
            rv_decode_pkg::f12_ebreak: sys_o.ebreak = 1'b1;
            rv_decode_pkg::f12_wfi:    sys_o.wfi = 1'b1;
            rv_decode_pkg::f12_dret:   sys_o.dret = 1'b1;
            rv_decode_pkg::f12_mret: begin
              // No return from user mode
              if (prv_i == rv_decode_pkg::prv_user) begin
                sys_o.illegal = 1'b1;
              end else begin
                sys_o.eret = 1'b1;
              end
            end
            default: sys_o.illegal = 1'b1;
          endcase
        end else begin
          sys_o.illegal = 1'b1;
        end
      end
      rv_decode_pkg::f3_csrrw, rv_decode_pkg::f3_csrrwi: begin
        sys_o.csr_cmd = rv_decode_pkg::csr_write;
      end
      // A zero rs1 or uimm only reads, no side effects on the CSR
      rv_decode_pkg::f3_csrrs, rv_decode_pkg::f3_csrrsi: begin
        sys_o.csr_cmd = rs1_zero ? rv_decode_pkg::csr_read : rv_decode_pkg::csr_set;
      end
      rv_decode_pkg::f3_csrrc, rv_decode_pkg::f3_csrrci: begin
        sys_o.csr_cmd = rs1_zero ? rv_decode_pkg::csr_read : rv_decode_pkg::csr_clear;
      end
      default: sys_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- test/decode_stimulus.hex
// ctl pc inst exp_pc exp_inst | exp ctrl nibbles w5 w6 w7 w8
// ctl: mode exp_c 0 stall kill inject prv comp; mode 1 checks before the edge
10010030 00000000 00000000 00001000 00000013 00101000 00010000 00000000 00000000
00000030 00000100 007302B3 00000100 007302B3 00001100 00010000 00000000 00000000
00010030 00000104 407302B3 00000100 007302B3 00001100 00010000 00000000 00000000
00001030 00000108 407302B3 00000100 00000013 00101000 00010000 00000000 00000000
01000131 0000010C 007302B3 0000010C 00100073 00101000 20000000 00010000 00000000
00000030 00000110 407302B3 00000110 407302B3 10001100 00010000 00000000 00000000
00000030 00000114 007312B3 00000114 007312B3 20001100 00010000 00000000 00000000
00000030 00000118 007322B3 00000118 007322B3 30001100 00010000 00000000 00000000
00000030 0000011C 007332B3 0000011C 007332B3 40001100 00010000 00000000 00000000
00000030 00000120 007342B3 00000120 007342B3 50001100 00010000 00000000 00000000
00000030 00000124 007352B3 00000124 007352B3 60001100 00010000 00000000 00000000
00000030 00000128 407352B3 00000128 407352B3 70001100 00010000 00000000 00000000
00000030 0000012C 007362B3 0000012C 007362B3 80001100 00010000 00000000 00000000
00000030 00000130 007372B3 00000130 007372B3 90001100 00010000 00000000 00000000
00000030 00000134 40030293 00000134 40030293 00101000 00010000 00000000 00000000
00000030 00000138 00133293 00000138 00133293 40101000 00010000 00000000 00000000
00000030 0000013C 00331293 0000013C 00331293 20101000 00010000 00000000 00000000
00000030 00000140 40335293 00000140 40335293 70101000 00010000 00000000 00000000
00000030 00000144 00730063 00000144 00730063 A0001100 00000000 00000000 00000000
00000030 00000148 00731063 00000148 00731063 B0001100 00000000 00000000 00000000
00000030 0000014C 00732063 0000014C 00732063 00001100 00001000 00000000 00000000
00000030 00000150 00733063 00000150 00733063 00001100 00001000 00000000 00000000
00000030 00000154 00734063 00000154 00734063 30001100 00000000 00000000 00000000
00000030 00000158 00735063 00000158 00735063 C0001100 00000000 00000000 00000000
00000030 0000015C 00736063 0000015C 00736063 40001100 00000000 00000000 00000000
00000030 00000160 00737063 00000160 00737063 D0001100 00000000 00000000 00000000
00000030 00000164 00032283 00000164 00032283 00101000 11010000 00000000 00000000
00000030 00000168 00732023 00000168 00732023 00101101 01100000 00000000 00000000
00000030 0000016C 000002EF 0000016C 000002EF 01200000 00010100 00000000 00000000
00000030 00000170 000302E7 00000170 000302E7 01201000 00010010 00000000 00000000
00000030 00000174 000312E7 00000174 000312E7 01201000 00011010 00000000 00000000
00000030 00000178 12345297 00000178 12345297 01100002 00010000 00000000 00000000
00000030 0000017C 123452B7 0000017C 123452B7 02100002 00010000 00000000 00000000
00000030 00000180 0FF0000F 00000180 0FF0000F 00101000 00000000 00000000 00000000
00000030 00000184 0FF0028F 00000184 0FF0028F 00101000 00001000 00000000 00000000
00000030 00000188 0000100F 00000188 0000100F 00101000 00000001 00000000 00000000
00000030 0000018C 0010100F 0000018C 0010100F 00101000 00001000 00000000 00000000
00000030 00000190 0000007F 00000190 0000007F 00101000 00001000 00000000 00000000
00000030 00000194 027302B3 00000194 027302B3 00001100 30010000 11000000 00000000
00000030 00000198 0073028B 00000198 0073028B 00011110 30010000 11000000 00000000
10001030 0000019C 00000013 00000198 0073028B 00011110 00010000 00000000 00000000
00000030 000001A0 00000073 000001A0 00000073 00101000 20000000 00100000 00000000
00000030 000001A4 10500073 000001A4 10500073 00101000 20000000 00000010 00000000
00000030 000001A8 7B200073 000001A8 7B200073 00101000 20000000 00000100 00000000
00000030 000001AC 30200073 000001AC 30200073 00101000 20000000 00001000 00000000
00000000 000001B0 30200073 000001B0 30200073 00101000 20001000 00000000 00100000
00000030 000001B4 300312F3 000001B4 300312F3 00101000 20010000 00000002 01000000
00000030 000001B8 300022F3 000001B8 300022F3 00101000 20010000 00000001 01000000
00000030 000001BC 300322F3 000001BC 300322F3 00101000 20010000 00000003 01000000
00000030 000001C0 300072F3 000001C0 300072F3 00101000 20010000 00000001 11000000
00000030 000001C4 300372F3 000001C4 300372F3 00101000 20010000 00000004 11000000
00000030 000001C8 300042F3 000001C8 300042F3 00101000 20011000 00000000 11100000
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF

//--- test/rv_decode_assertions.sv
// ------------------------------------------------------------
// Concurrent checks on the decode stage, bound to rv_decode
// Covers kill, stall, PCPI gating and unknown opcodes
// ------------------------------------------------------------
`timescale 1ns/1ps

module rv_decode_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    stall_i,
  input logic                    kill_i,
  input rv_decode_pkg::de_inst_t de_o,
  input rv_decode_pkg::de_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic       known_opcode;

  assign opcode       = de_o.inst[6:0];
  assign known_opcode = opcode inside {
    rv_decode_pkg::opc_load, rv_decode_pkg::opc_custom, rv_decode_pkg::opc_misc_mem,
    rv_decode_pkg::opc_op_imm, rv_decode_pkg::opc_auipc, rv_decode_pkg::opc_store,
    rv_decode_pkg::opc_op, rv_decode_pkg::opc_lui, rv_decode_pkg::opc_branch,
    rv_decode_pkg::opc_jalr, rv_decode_pkg::opc_jal, rv_decode_pkg::opc_system
  };

  kill_gives_nop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_i |=> (de_o.inst == rv_decode_pkg::rv_nop))
    else $error("kill did not load a NOP into the IF/DE register");

  stall_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_i && !kill_i) |=> $stable(de_o))
    else $error("IF/DE register changed during a stall");

  no_pcpi_on_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(kill_i && ctrl_o.pcpi_valid))
    else $error("PCPI request raised while kill is active");

  unknown_no_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !known_opcode |-> (ctrl_o.illegal && !ctrl_o.wr_reg))
    else $error("unknown opcode not flagged illegal or writes a register");

endmodule

bind rv_decode rv_decode_assertions u_rv_decode_assertions (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .stall_i (stall_i),
  .kill_i  (kill_i),
  .de_o    (de_o),
  .ctrl_o  (ctrl_o)
);

//--- test/tb_clock_gen.sv
// ------------------------------------------------------------
// Testbench clock and reset source
// 10 ns clock, active-low reset held for four rising edges
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- test/tb_rv_decode.sv
// ------------------------------------------------------------
// Vector testbench for the RV32 decode stage
// Reads test/decode_stimulus.hex, drives on falling edges and
// compares de_o and ctrl_o, with random stalls between vectors
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_rv_decode;

  localparam logic [31:0] start_pc    = 32'h0000_1000;
  localparam int          max_words   = 1024;
  localparam int          vec_words   = 9;
  localparam int          cycle_limit = 5000;

  logic                     clk;
  logic                     rst_n;
  logic [31:0]              inst_i;
  logic [31:0]              pc_i;
  logic                     compressed_i;
  logic                     stall_i;
  logic                     kill_i;
  logic                     inject_ebreak_i;
  rv_decode_pkg::prv_e      prv_i;
  rv_decode_pkg::de_inst_t  de_o;
  rv_decode_pkg::de_ctrl_t  ctrl_o;

  logic [31:0] stim_mem [0:max_words-1];
  logic [31:0] rng_state;
  int          checks;
  int          de_errors;
  int          ctrl_errors;
  int          other_errors;

  tb_clock_gen u_tb_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  rv_decode #(
    .start_pc (start_pc)
  ) u_rv_decode (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .compressed_i    (compressed_i),
    .stall_i         (stall_i),
    .kill_i          (kill_i),
    .inject_ebreak_i (inject_ebreak_i),
    .prv_i           (prv_i),
    .de_o            (de_o),
    .ctrl_o          (ctrl_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Flags take one nibble each and register fields come from the word
  function automatic rv_decode_pkg::de_ctrl_t build_ctrl(
    input logic [31:0] inst, input logic [31:0] w5, input logic [31:0] w6,
    input logic [31:0] w7, input logic [31:0] w8
  );
    rv_decode_pkg::de_ctrl_t c;
    c                 = '0;
    c.alu_op          = rv_decode_pkg::alu_op_e'(w5[31:28]);
    c.src_a_sel       = rv_decode_pkg::src_a_sel_e'(w5[25:24]);
    c.src_b_sel       = rv_decode_pkg::src_b_sel_e'(w5[21:20]);
    c.src_c_sel       = rv_decode_pkg::src_c_sel_e'(w5[16]);
    c.uses_rs1        = w5[12];
    c.uses_rs2        = w5[8];
    c.uses_rs3        = w5[4];
    c.imm_type        = rv_decode_pkg::imm_type_e'(w5[1:0]);
    c.rs1_addr        = inst[19:15];
    c.rs2_addr        = inst[24:20];
    c.rs3_addr        = inst[11:7];
    c.dmem_size       = {1'b0, inst[13:12]};
    c.dmem_type       = inst[14:12];
    c.wb_src_sel      = rv_decode_pkg::wb_src_sel_e'(w6[29:28]);
    c.dmem_en         = w6[24];
    c.dmem_wen        = w6[20];
    c.wr_reg          = w6[16];
    c.illegal         = w6[12];
    c.jal             = w6[8];
    c.jalr            = w6[4];
    c.fence_i         = w6[0];
    c.pcpi_valid      = w7[28];
    c.uses_pcpi       = w7[24];
    c.sys.ecall       = w7[20];
    c.sys.ebreak      = w7[16];
    c.sys.eret        = w7[12];
    c.sys.dret        = w7[8];
    c.sys.wfi         = w7[4];
    c.sys.csr_cmd     = rv_decode_pkg::csr_cmd_e'(w7[2:0]);
    c.sys.csr_imm_sel = w8[28];
    c.sys.wr_reg      = w8[24];
    c.sys.illegal     = w8[20];
    return c;
  endfunction

  task automatic compare_de(input rv_decode_pkg::de_inst_t actual,
                            input rv_decode_pkg::de_inst_t expected, input int vec);
    checks++;
    if (actual !== expected) begin
      de_errors++;
      $display("MISMATCH de_o vector %0d: got %h expected %h", vec, actual, expected);
    end
  endtask

  task automatic compare_ctrl(input rv_decode_pkg::de_ctrl_t actual,
                              input rv_decode_pkg::de_ctrl_t expected, input int vec);
    checks++;
    if (actual !== expected) begin
      ctrl_errors++;
      $display("MISMATCH ctrl_o vector %0d: got %h expected %h", vec, actual, expected);
    end
  endtask

  task automatic wait_reset_release(output bit released);
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    released = (rst_n === 1'b1);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_vector(input int vec);
    int                      base;
    logic [31:0]             w0;
    int                      stalls;
    rv_decode_pkg::de_inst_t exp_de;
    rv_decode_pkg::de_ctrl_t exp_ctrl;
    base            = vec * vec_words;
    w0              = stim_mem[base];
    stall_i         = w0[16];
    kill_i          = w0[12];
    inject_ebreak_i = w0[8];
    prv_i           = rv_decode_pkg::prv_e'(w0[5:4]);
    compressed_i    = w0[0];
    pc_i            = stim_mem[base+1];
    inst_i          = stim_mem[base+2];
    exp_de          = {stim_mem[base+3], stim_mem[base+4], w0[24]};
    exp_ctrl        = build_ctrl(stim_mem[base+4], stim_mem[base+5], stim_mem[base+6],
                                 stim_mem[base+7], stim_mem[base+8]);
    if (w0[28]) begin
      // Present state with the new inputs applied, before the coming edge
      #1;
      compare_de(de_o, exp_de, vec);
      compare_ctrl(ctrl_o, exp_ctrl, vec);
      @(negedge clk);
    end else begin
      @(negedge clk);
      compare_de(de_o, exp_de, vec);
      compare_ctrl(ctrl_o, exp_ctrl, vec);
      rng_state = xorshift32(rng_state);
      stalls    = int'(rng_state % 3);
      for (int i = 0; i < stalls; i++) begin
        rng_state       = xorshift32(rng_state);
        stall_i         = 1'b1;
        kill_i          = 1'b0;
        inject_ebreak_i = rng_state[0];
        compressed_i    = rng_state[1];
        pc_i            = rng_state;
        inst_i          = ~rng_state;
        @(negedge clk);
        compare_de(de_o, exp_de, vec);
        compare_ctrl(ctrl_o, exp_ctrl, vec);
      end
    end
  endtask

  initial begin
    for (int i = 0; i < cycle_limit; i++) begin
      @(posedge clk);
    end
    $display("simulation did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    bit released;
    int vec;
    inst_i          = '0;
    pc_i            = '0;
    compressed_i    = 1'b0;
    stall_i         = 1'b1;
    kill_i          = 1'b0;
    inject_ebreak_i = 1'b0;
    prv_i           = rv_decode_pkg::prv_machine;
    rng_state       = 32'd35;
    checks          = 0;
    de_errors       = 0;
    ctrl_errors     = 0;
    other_errors    = 0;
    $readmemh("test/decode_stimulus.hex", stim_mem);
    wait_reset_release(released);
    if (!released) begin
      $display("reset was not released in time");
      $display("** FAIL **");
      $finish;
    end else begin
      @(negedge clk);
      vec = 0;
      while ((vec + 1) * vec_words <= max_words &&
             stim_mem[vec*vec_words] !== 32'hffff_ffff &&
             !$isunknown(stim_mem[vec*vec_words])) begin
        run_vector(vec);
        vec++;
      end
      if (vec == 0) begin
        other_errors++;
        $display("no stimulus vectors were read");
      end
      $display("vectors %0d, checks %0d, de_o errors %0d, ctrl_o errors %0d, other errors %0d",
               vec, checks, de_errors, ctrl_errors, other_errors);
      if (de_errors + ctrl_errors + other_errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule
